//--- Makefile
# Verilator build and run for the non-computational FPU testbench

VERILATOR ?= verilator
TOP       ?= fpu_ncp_tb
FILELIST  ?= fpu_ncp.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- fpu_ncp.f
src/fpu_ncp_pkg.sv
src/fpu_ncp_dispatch.sv
src/fpu_cmp_unit.sv
src/fpu_sgn_unit.sv
src/fpu_rsp_arb.sv
src/fpu_ncp.sv
testbench/fpu_ncp_tb.sv

//--- src/fpu_cmp_unit.sv
/*
 * compare and min/max unit with IEEE NaN handling and invalid flag,
 * followed by a stalling shift pipeline
 */
`timescale 1ns/1ps

module fpu_cmp_unit #(
    parameter int LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  fpu_ncp_pkg::fpu_op_e  op,
    input  fpu_ncp_pkg::fpu_req_t req,
    output logic                  ready,
    output logic                  rsp_valid,
    output fpu_ncp_pkg::fpu_rsp_t rsp,
    input  logic                  rsp_ready
);
    import fpu_ncp_pkg::*;

    function automatic logic is_nan(fp32_t x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic is_snan(fp32_t x);
        return is_nan(x) && !x[22];
    endfunction

    // less-than on non-NaN values, with -0 below +0 only when signed_zero is set
    function automatic logic fp_less(fp32_t x, fp32_t y, logic signed_zero);
        logic res;
        if (!signed_zero && (x[30:0] == 31'd0) && (y[30:0] == 31'd0)) begin
            res = 1'b0;
        end else if (x[31] != y[31]) begin
            res = x[31];
        end else if (x[31]) begin
            res = x[30:0] > y[30:0];
        end else begin
            res = x[30:0] < y[30:0];
        end
        return res;
    endfunction

    fp32_t [FPU_LANES-1:0] lane_res;
    logic  [FPU_LANES-1:0] lane_nv;
    fpu_rsp_t              rsp_d;

    for (genvar i = 0; i < FPU_LANES; i++) begin : g_lane
        fp32_t a;
        fp32_t b;
        logic  any_nan;
        logic  any_snan;
        logic  lt;
        logic  eq;
        logic  lt_signed;
        fp32_t min_max;
        fp32_t res;
        logic  nv;

        assign a         = req.a[i];
        assign b         = req.b[i];
        assign any_nan   = is_nan(a) || is_nan(b);
        assign any_snan  = is_snan(a) || is_snan(b);
        assign lt        = fp_less(a, b, 1'b0);
        assign eq        = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));
        assign lt_signed = fp_less(a, b, 1'b1);

        // frm[0] picks max over min
        always_comb begin
            if (is_nan(a) && is_nan(b)) begin
                min_max = CANONICAL_NAN;
            end else if (is_nan(a)) begin
                min_max = b;
            end else if (is_nan(b)) begin
                min_max = a;
            end else if (req.frm[0]) begin
                min_max = lt_signed ? b : a;
            end else begin
                min_max = lt_signed ? a : b;
            end
        end

        always_comb begin
            res = '0;
            nv  = 1'b0;
            if (op == FPU_OP_CMP) begin
                case (req.frm)
                    3'd0: begin
                        res[0] = !any_nan && (lt || eq);
                        nv     = any_nan;
                    end
                    3'd1: begin
                        res[0] = !any_nan && lt;
                        nv     = any_nan;
                    end
                    3'd2: begin
                        res[0] = !any_nan && eq;
                        nv     = any_snan;
                    end
                    default: begin
                        res = '0;
                        nv  = 1'b0;
                    end
                endcase
            end else begin
                res = min_max;
                nv  = any_snan;
            end
        end

        assign lane_res[i] = res;
        assign lane_nv[i]  = nv;
    end

    always_comb begin
        rsp_d            = '0;
        rsp_d.result     = lane_res;
        rsp_d.has_fflags = 1'b1;
        rsp_d.fflags.nv  = |(lane_nv & req.lane_mask);
        rsp_d.tag        = req.tag;
    end

    ////////////////////
    // pipeline

    logic [LATENCY-1:0] vld_q;
    fpu_rsp_t           data_q [LATENCY];
    logic               advance;

    // the whole pipeline freezes while its output waits
    assign advance = !rsp_valid || rsp_ready;
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q[0] <= valid;
            for (int s = 1; s < LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            data_q[0] <= rsp_d;
            for (int s = 1; s < LATENCY; s++) begin
                data_q[s] <= data_q[s-1];
            end
        end
    end

    assign rsp_valid = vld_q[LATENCY-1];
    assign rsp       = data_q[LATENCY-1];

    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("compare response changed while held");

endmodule

//--- src/fpu_ncp.sv
/*
 * top level of the non-computational FPU, dispatch, two units and arbiter
 */
`timescale 1ns/1ps

module fpu_ncp #(
    parameter int CMP_LATENCY = 2,
    parameter int SGN_LATENCY = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_in,
    output logic                  ready_in,
    input  fpu_ncp_pkg::fpu_op_e  op,
    input  fpu_ncp_pkg::fpu_req_t req,
    output logic                  valid_out,
    output fpu_ncp_pkg::fpu_rsp_t rsp,
    input  logic                  ready_out
);
    import fpu_ncp_pkg::*;

    logic     cmp_valid;
    logic     sgn_valid;
    logic     cmp_ready;
    logic     sgn_ready;
    logic     cmp_rsp_valid;
    logic     sgn_rsp_valid;
    logic     cmp_rsp_ready;
    logic     sgn_rsp_ready;
    fpu_rsp_t cmp_rsp;
    fpu_rsp_t sgn_rsp;

    fpu_ncp_dispatch u_dispatch (
        .valid_in  (valid_in),
        .op        (op),
        .frm       (req.frm),
        .cmp_ready (cmp_ready),
        .sgn_ready (sgn_ready),
        .cmp_valid (cmp_valid),
        .sgn_valid (sgn_valid),
        .ready_in  (ready_in)
    );

    fpu_cmp_unit #(
        .LATENCY (CMP_LATENCY)
    ) u_cmp_unit (
        .clk       (clk),
        .reset     (reset),
        .valid     (cmp_valid),
        .op        (op),
        .req       (req),
        .ready     (cmp_ready),
        .rsp_valid (cmp_rsp_valid),
        .rsp       (cmp_rsp),
        .rsp_ready (cmp_rsp_ready)
    );

    fpu_sgn_unit #(
        .LATENCY (SGN_LATENCY)
    ) u_sgn_unit (
        .clk       (clk),
        .reset     (reset),
        .valid     (sgn_valid),
        .req       (req),
        .ready     (sgn_ready),
        .rsp_valid (sgn_rsp_valid),
        .rsp       (sgn_rsp),
        .rsp_ready (sgn_rsp_ready)
    );

    fpu_rsp_arb u_rsp_arb (
        .clk       (clk),
        .reset     (reset),
        .cmp_valid (cmp_rsp_valid),
        .sgn_valid (sgn_rsp_valid),
        .cmp_rsp   (cmp_rsp),
        .sgn_rsp   (sgn_rsp),
        .cmp_ready (cmp_rsp_ready),
        .sgn_ready (sgn_rsp_ready),
        .valid_out (valid_out),
        .rsp       (rsp),
        .ready_out (ready_out)
    );

endmodule

//--- src/fpu_ncp_dispatch.sv
/*
 * request steering between the compare and sign-injection units
 */
`timescale 1ns/1ps

module fpu_ncp_dispatch (
    input  logic                 valid_in,
    input  fpu_ncp_pkg::fpu_op_e op,
    input  fpu_ncp_pkg::frm_t    frm,
    input  logic                 cmp_ready,
    input  logic                 sgn_ready,
    output logic                 cmp_valid,
    output logic                 sgn_valid,
    output logic                 ready_in
);
    import fpu_ncp_pkg::*;

    logic to_cmp;

    // min and max share the comparator, so they go to the compare unit
    always_comb begin
        to_cmp = 1'b0;
        if (op == FPU_OP_CMP) begin
            to_cmp = 1'b1;
        end else begin
            case (frm)
                3'd6,
                3'd7:    to_cmp = 1'b1;
                default: to_cmp = 1'b0;
            endcase
        end
    end

    assign cmp_valid = valid_in && to_cmp;
    assign sgn_valid = valid_in && !to_cmp;

    // the source only sees the ready of the unit it is aimed at
    assign ready_in = to_cmp ? cmp_ready : sgn_ready;

    always_comb begin
        assert (!(cmp_valid && sgn_valid))
            else $error("request steered to both units");
    end

endmodule

//--- src/fpu_ncp_pkg.sv
/*
 * constants, vector types, IEEE flag struct, request and response structs
 * and the operation encoding shared by the non-computational FPU blocks
 */
package fpu_ncp_pkg;

    localparam int FPU_LANES = 4;
    localparam int FPU_TAG_W = 4;

    typedef logic [31:0]          fp32_t;
    typedef logic [FPU_LANES-1:0] lane_mask_t;
    typedef logic [FPU_TAG_W-1:0] tag_t;
    typedef logic [2:0]           frm_t;

    // quiet NaN with only the top mantissa bit set
    localparam fp32_t CANONICAL_NAN = 32'h7fc00000;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // frm selects the operation inside each group
    //   CMP  0 fle, 1 flt, 2 feq
    //   MISC 0 sgnj, 1 sgnjn, 2 sgnjx, 3 class, 6 min, 7 max
    typedef enum logic {
        FPU_OP_CMP  = 1'b0,
        FPU_OP_MISC = 1'b1
    } fpu_op_e;

    typedef struct packed {
        tag_t                  tag;
        lane_mask_t            lane_mask;
        frm_t                  frm;
        fp32_t [FPU_LANES-1:0] a;
        fp32_t [FPU_LANES-1:0] b;
    } fpu_req_t;

    typedef struct packed {
        fp32_t [FPU_LANES-1:0] result;
        logic                  has_fflags;
        fflags_t               fflags;
        tag_t                  tag;
    } fpu_rsp_t;

endpackage

//--- src/fpu_rsp_arb.sv
/*
 * two-input round-robin response arbiter with valid/ready
 */
`timescale 1ns/1ps

module fpu_rsp_arb (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp_valid,
    input  logic                  sgn_valid,
    input  fpu_ncp_pkg::fpu_rsp_t cmp_rsp,
    input  fpu_ncp_pkg::fpu_rsp_t sgn_rsp,
    output logic                  cmp_ready,
    output logic                  sgn_ready,
    output logic                  valid_out,
    output fpu_ncp_pkg::fpu_rsp_t rsp,
    input  logic                  ready_out
);
    import fpu_ncp_pkg::*;

    logic prio_q;
    logic lock_q;
    logic lock_sel_q;
    logic pick_sgn;
    logic sel_sgn;
    logic fire;

    // prio_q low favors the compare unit
    assign pick_sgn = sgn_valid && (!cmp_valid || prio_q);

    // a stalled output keeps its grant even if the other unit turns valid
    assign sel_sgn = lock_q ? lock_sel_q : pick_sgn;

    assign valid_out = sel_sgn ? sgn_valid : cmp_valid;
    assign rsp       = sel_sgn ? sgn_rsp : cmp_rsp;
    assign cmp_ready = ready_out && !sel_sgn;
    assign sgn_ready = ready_out && sel_sgn;
    assign fire      = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_q     <= 1'b0;
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else begin
            if (fire) begin
                prio_q <= !sel_sgn;
                lock_q <= 1'b0;
            end else if (valid_out) begin
                lock_q     <= 1'b1;
                lock_sel_q <= sel_sgn;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(rsp))
        else $error("held response dropped before it was accepted");

endmodule

//--- src/fpu_sgn_unit.sv
/*
 * sign-injection and classify unit with a stalling shift pipeline
 */
`timescale 1ns/1ps

module fpu_sgn_unit #(
    parameter int LATENCY = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  fpu_ncp_pkg::fpu_req_t req,
    output logic                  ready,
    output logic                  rsp_valid,
    output fpu_ncp_pkg::fpu_rsp_t rsp,
    input  logic                  rsp_ready
);
    import fpu_ncp_pkg::*;

    // RISC-V fclass mask, bit 0 is -inf and bit 9 is a quiet NaN
    function automatic logic [9:0] fp_class(fp32_t x);
        logic       exp_ones;
        logic       exp_zero;
        logic       man_zero;
        logic [9:0] mask;
        exp_ones = x[30:23] == 8'hff;
        exp_zero = x[30:23] == 8'h00;
        man_zero = x[22:0] == 23'd0;
        mask[0] = x[31] && exp_ones && man_zero;
        mask[1] = x[31] && !exp_ones && !exp_zero;
        mask[2] = x[31] && exp_zero && !man_zero;
        mask[3] = x[31] && exp_zero && man_zero;
        mask[4] = !x[31] && exp_zero && man_zero;
        mask[5] = !x[31] && exp_zero && !man_zero;
        mask[6] = !x[31] && !exp_ones && !exp_zero;
        mask[7] = !x[31] && exp_ones && man_zero;
        mask[8] = exp_ones && !man_zero && !x[22];
        mask[9] = exp_ones && x[22];
        return mask;
    endfunction

    fpu_rsp_t rsp_d;

    always_comb begin
        rsp_d     = '0;
        rsp_d.tag = req.tag;
        for (int i = 0; i < FPU_LANES; i++) begin
            case (req.frm)
                3'd0:    rsp_d.result[i] = {req.b[i][31], req.a[i][30:0]};
                3'd1:    rsp_d.result[i] = {!req.b[i][31], req.a[i][30:0]};
                3'd2:    rsp_d.result[i] = {req.a[i][31] ^ req.b[i][31], req.a[i][30:0]};
                3'd3:    rsp_d.result[i] = {22'd0, fp_class(req.a[i])};
                default: rsp_d.result[i] = '0;
            endcase
        end
    end

    ////////////////////
    // pipeline

    logic [LATENCY-1:0] vld_q;
    fpu_rsp_t           data_q [LATENCY];
    logic               advance;

    assign advance = !rsp_valid || rsp_ready;
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q[0] <= valid;
            for (int s = 1; s < LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            data_q[0] <= rsp_d;
            for (int s = 1; s < LATENCY; s++) begin
                data_q[s] <= data_q[s-1];
            end
        end
    end

    assign rsp_valid = vld_q[LATENCY-1];
    assign rsp       = data_q[LATENCY-1];

endmodule

//--- testbench/fpu_ncp_tb.sv
/*
 * clock and reset, LCG operands, reference model, compare tasks
 * and directed tests for the non-computational FPU
 */
`timescale 1ns/1ps

module fpu_ncp_tb;
    import fpu_ncp_pkg::*;

    typedef fp32_t [FPU_LANES-1:0] lanes_t;
    localparam int TIMEOUT = 200;
    localparam int NTAGS   = 1 << FPU_TAG_W;

    logic     clk;
    logic     reset;
    logic     valid_in;
    logic     ready_in;
    fpu_op_e  op;
    fpu_req_t req;
    logic     valid_out;
    fpu_rsp_t rsp;
    logic     ready_out;

    logic [31:0]      lcg_state;
    tag_t             next_tag;
    fpu_rsp_t         rx_q [$];
    fpu_rsp_t         exp_by_tag [NTAGS];
    logic [NTAGS-1:0] pending;
    logic             held;
    fpu_rsp_t         held_rsp;
    logic             saw_stall;

    fpu_ncp #(.CMP_LATENCY(2), .SGN_LATENCY(1)) u_fpu_ncp (
        .clk(clk), .reset(reset), .valid_in(valid_in), .ready_in(ready_in), .op(op),
        .req(req), .valid_out(valid_out), .rsp(rsp), .ready_out(ready_out)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input fpu_rsp_t exp, input fpu_rsp_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h actual %h", name, exp, act);
            stop_run("wrong response");
        end
    endtask

    task automatic check_fflags(input string name, input fflags_t exp, input fflags_t act);
        if (act !== exp) begin
            $display("** Error %s: expected fflags %b actual %b", name, exp, act);
            stop_run("wrong exception flags");
        end
    endtask

    ////////////////////
    // reference model

    function automatic logic [31:0] rand_u32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic lanes_t rand_lanes();
        lanes_t v;
        for (int i = 0; i < FPU_LANES; i++) begin
            v[i] = rand_u32();
        end
        return v;
    endfunction

    // 0 for a number, 1 for a quiet NaN, 2 for a signaling NaN
    function automatic int nan_kind(input fp32_t x);
        if (x[30:23] != 8'hff || x[22:0] == 23'd0) return 0;
        return x[22] ? 1 : 2;
    endfunction

    // sign-magnitude folded onto a signed line, both zeros land on 0
    function automatic logic signed [31:0] order_key(input fp32_t x);
        logic signed [31:0] mag;
        mag = {1'b0, x[30:0]};
        return x[31] ? -mag : mag;
    endfunction

    function automatic fp32_t min_max_ref(input fp32_t a, input fp32_t b, input logic want_max);
        if (nan_kind(a) != 0 && nan_kind(b) != 0) return CANONICAL_NAN;
        if (nan_kind(a) != 0) return b;
        if (nan_kind(b) != 0) return a;
        if (order_key(a) == order_key(b)) begin
            // only the zero sign can differ here, and -0 counts as the smaller
            if (want_max) return a[31] ? b : a;
            return a[31] ? a : b;
        end
        if (want_max) return (order_key(a) > order_key(b)) ? a : b;
        return (order_key(a) < order_key(b)) ? a : b;
    endfunction

    function automatic fp32_t class_mask(input fp32_t x);
        int idx;
        if (x[30:23] == 8'hff) begin
            idx = (x[22:0] == 23'd0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
        end else if (x[30:23] == 8'h00) begin
            idx = (x[22:0] == 23'd0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
        end else begin
            idx = x[31] ? 1 : 6;
        end
        return fp32_t'(1) << idx;
    endfunction

    function automatic fpu_rsp_t model_rsp(input fpu_op_e o, input fpu_req_t r);
        fpu_rsp_t           e;
        logic               nv;
        logic               any_nan;
        logic               any_snan;
        logic signed [31:0] ka;
        logic signed [31:0] kb;
        e     = '0;
        e.tag = r.tag;
        nv    = 1'b0;
        for (int i = 0; i < FPU_LANES; i++) begin
            any_nan  = nan_kind(r.a[i]) != 0 || nan_kind(r.b[i]) != 0;
            any_snan = nan_kind(r.a[i]) == 2 || nan_kind(r.b[i]) == 2;
            ka       = order_key(r.a[i]);
            kb       = order_key(r.b[i]);
            if (o == FPU_OP_CMP) begin
                e.has_fflags = 1'b1;
                case (r.frm)
                    3'd0:    e.result[i] = {31'd0, (!any_nan && (ka <= kb))};
                    3'd1:    e.result[i] = {31'd0, (!any_nan && (ka < kb))};
                    3'd2:    e.result[i] = {31'd0, (!any_nan && (ka == kb))};
                    default: e.result[i] = '0;
                endcase
                if (r.frm < 3'd2) begin
                    nv = nv | (r.lane_mask[i] && any_nan);
                end else if (r.frm == 3'd2) begin
                    nv = nv | (r.lane_mask[i] && any_snan);
                end
            end else if (r.frm == 3'd6 || r.frm == 3'd7) begin
                e.has_fflags = 1'b1;
                e.result[i]  = min_max_ref(r.a[i], r.b[i], r.frm == 3'd7);
                nv           = nv | (r.lane_mask[i] && any_snan);
            end else begin
                case (r.frm)
                    3'd0:    e.result[i] = {r.b[i][31], r.a[i][30:0]};
                    3'd1:    e.result[i] = {~r.b[i][31], r.a[i][30:0]};
                    3'd2:    e.result[i] = {r.a[i][31] ^ r.b[i][31], r.a[i][30:0]};
                    3'd3:    e.result[i] = class_mask(r.a[i]);
                    default: e.result[i] = '0;
                endcase
            end
        end
        e.fflags.nv = nv;
        return e;
    endfunction

    ////////////////////
    // bus handling

    // samples between edges, where every DUT output has settled
    always @(negedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            if (held && !valid_out) begin
                stop_run("valid_out dropped while a response was held");
            end else if (held) begin
                check_rsp("held output", held_rsp, rsp);
            end
            if (valid_in && !ready_in) saw_stall = 1'b1;
            if (valid_out && ready_out) rx_q.push_back(rsp);
            held     = valid_out && !ready_out;
            held_rsp = rsp;
        end
    end

    task automatic send_req(input fpu_op_e req_op, input fpu_req_t req_val);
        int   cycles;
        logic done;
        cycles   = 0;
        done     = 1'b0;
        op       = req_op;
        req      = req_val;
        valid_in = 1'b1;
        while (!done) begin
            @(negedge clk);
            done = ready_in;
            @(posedge clk);
            #1;
            cycles++;
            if (!done && cycles > TIMEOUT) stop_run("request was not accepted in time");
        end
        valid_in = 1'b0;
    endtask

    task automatic wait_rx(input int n, input string name);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) stop_run({name, ": response did not arrive in time"});
        end
    endtask

    task automatic exercise(input string name, input fpu_op_e o, input frm_t frm,
                            input lane_mask_t mask, input lanes_t a, input lanes_t b,
                            output fpu_rsp_t got);
        fpu_req_t r;
        fpu_rsp_t exp;
        r        = '{tag: next_tag, lane_mask: mask, frm: frm, a: a, b: b};
        next_tag = next_tag + 1'b1;
        exp      = model_rsp(o, r);
        send_req(o, r);
        wait_rx(1, name);
        got = rx_q.pop_front();
        check_fflags(name, exp.fflags, got.fflags);
        check_rsp(name, exp, got);
    endtask

    task automatic issue_random();
        fpu_req_t    r;
        fpu_op_e     o;
        logic [31:0] pick;
        int          m;
        pick        = rand_u32();
        m           = int'(pick[15:0] % 16'd6);
        o           = pick[31] ? FPU_OP_MISC : FPU_OP_CMP;
        r.tag       = next_tag;
        r.lane_mask = lane_mask_t'(pick[7:4]);
        r.frm       = (o == FPU_OP_CMP) ? frm_t'(m % 3) : frm_t'((m < 4) ? m : m + 2);
        r.a         = rand_lanes();
        r.b         = rand_lanes();
        next_tag    = next_tag + 1'b1;
        exp_by_tag[r.tag] = model_rsp(o, r);
        pending[r.tag]    = 1'b1;
        send_req(o, r);
    endtask

    // responses come back by tag, in whatever order the arbiter picks
    task automatic collect_stream(input int n, input string name);
        fpu_rsp_t got;
        wait_rx(n, name);
        for (int k = 0; k < n; k++) begin
            got = rx_q.pop_front();
            if (!pending[got.tag]) stop_run({name, ": response with unknown or repeated tag"});
            check_rsp(name, exp_by_tag[got.tag], got);
            pending[got.tag] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        if (pending != '0 || rx_q.size() != 0) stop_run({name, ": response lost or duplicated"});
    endtask

    ////////////////////
    // tests

    task automatic test_compare();
        lanes_t   a;
        lanes_t   b;
        fpu_rsp_t got;
        for (int f = 0; f < 3; f++) begin
            a = rand_lanes();
            b = rand_lanes();
            exercise("compare random", FPU_OP_CMP, frm_t'(f), 4'hf, a, b, got);
            exercise("compare equal", FPU_OP_CMP, frm_t'(f), 4'hf, a, a, got);
            a = {32'h3f800000, 32'h00000000, 32'h80000000, 32'hc0000000};
            b = {32'h3f800000, 32'h80000000, 32'h00000000, 32'h40000000};
            exercise("compare zeros", FPU_OP_CMP, frm_t'(f), 4'hf, a, b, got);
            a = {32'h7fc00001, 32'h7f800001, 32'h3f800000, 32'hff800000};
            b = {32'h3f800000, 32'h40000000, 32'h7fa00000, 32'hffc00000};
            exercise("compare nan", FPU_OP_CMP, frm_t'(f), 4'hf, a, b, got);
            // signaling NaN only in lane 3, which the mask switches off
            a = {32'h7f800001, 32'h3f800000, 32'hbf800000, 32'h00000000};
            exercise("compare masked", FPU_OP_CMP, frm_t'(f), 4'b0111, a, a, got);
            check_fflags("compare masked", fflags_t'(5'b0), got.fflags);
        end
    endtask

    task automatic test_minmax();
        lanes_t   a;
        lanes_t   b;
        fpu_rsp_t got;
        a = {32'h7fc00000, 32'h7fc00000, 32'h7f800001, 32'h80000000};
        b = {32'h3f800000, 32'h7f800001, 32'hc0000000, 32'h00000000};
        for (int f = 6; f < 8; f++) begin
            exercise("minmax nan", FPU_OP_MISC, frm_t'(f), 4'hf, a, b, got);
            exercise("minmax swapped", FPU_OP_MISC, frm_t'(f), 4'hf, b, a, got);
            exercise("minmax random", FPU_OP_MISC, frm_t'(f), 4'hf, rand_lanes(),
                     rand_lanes(), got);
        end
    endtask

    task automatic test_sign_class();
        lanes_t   a [3];
        lanes_t   b [3];
        fpu_rsp_t got;
        a[0] = {32'h7f800000, 32'hff800000, 32'h00000001, 32'h80000000};
        b[0] = {32'h80000000, 32'h3f800000, 32'hff800000, 32'h7fc00000};
        a[1] = {32'h7fc00000, 32'h7f800001, 32'h807fffff, 32'h00000000};
        b[1] = {32'h00000000, 32'h80000001, 32'h7f800000, 32'hc0000000};
        a[2] = rand_lanes();
        b[2] = rand_lanes();
        for (int f = 0; f < 6; f++) begin
            for (int s = 0; s < 3; s++) begin
                exercise("sign and class", FPU_OP_MISC, frm_t'(f), 4'hf, a[s], b[s], got);
            end
        end
    endtask

    task automatic test_backpressure();
        saw_stall = 1'b0;
        ready_out = 1'b0;
        fork
            begin
                for (int k = 0; k < 8; k++) issue_random();
            end
            begin
                repeat (10) @(posedge clk);
                #1;
                ready_out = 1'b1;
            end
        join
        if (!saw_stall) stop_run("ready_in never dropped while the output was held");
        collect_stream(8, "back-pressure");
    endtask

    task automatic test_reset();
        int cycles;
        cycles    = 0;
        ready_out = 1'b0;
        send_req(FPU_OP_MISC, '{tag: next_tag, lane_mask: 4'hf, frm: 3'd0, a: '1, b: '0});
        next_tag = next_tag + 1'b1;
        while (!valid_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) stop_run("no response appeared before the reset test");
        end
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset     = 1'b0;
        ready_out = 1'b1;
        @(negedge clk);
        if (valid_out !== 1'b0) stop_run("valid_out is high after reset");
        repeat (5) @(posedge clk);
        if (rx_q.size() != 0) stop_run("a response survived the reset");
    endtask

    initial begin
        lcg_state  = 32'd32;
        next_tag   = '0;
        pending    = '0;
        held       = 1'b0;
        saw_stall  = 1'b0;
        reset      = 1'b1;
        valid_in   = 1'b0;
        op         = FPU_OP_CMP;
        req        = '0;
        ready_out  = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (valid_out !== 1'b0) stop_run("valid_out is high after the first reset");
        @(posedge clk);
        #1;
        test_compare();
        test_minmax();
        test_sign_class();
        for (int k = 0; k < 12; k++) issue_random();
        collect_stream(12, "mixed stream");
        test_backpressure();
        test_reset();
        $display("TEST OK");
        $finish;
    end

endmodule
